// File: vlog.f
vector_pkg.sv
point_ram.sv
screen_source.sv
dwell_timer.sv
beam_sequencer.sv
axil_point_port.sv
vector_display_top.sv
tb_clock.sv
vector_display_props.sv
vector_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vector_display_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: vector_display_tb.sv
// random frame testbench for the vector display: axi host master, frame model and dac monitor
module vector_display_tb import vector_pkg::*;;

    localparam int         POINT_ADDR_W = 8;
    localparam int         DWELL_CYCLES = 4;
    localparam int         QUIET        = 3 * (DWELL_CYCLES + 2);
    localparam logic [1:0] RESP_OKAY    = 2'b00;

    logic        clk;
    logic        arst_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    coord_t      x_dac;
    coord_t      y_dac;
    logic        dac_load;
    logic        beam_on;
    logic        halt;

    int unsigned lcg_state = 7951;
    int          cycle     = 0;
    int          limit     = 1000000;
    int          halt_rises = 0;
    logic        halt_prev  = 1'b0;
    int          frames     = 0;
    point_word_t model_ram [2**POINT_ADDR_W];
    coord_t      seen_x [$];
    coord_t      seen_y [$];
    logic        seen_on [$];
    int          seen_cyc [$];

    tb_clock #(.PERIOD(10), .RESET_CYCLES(10)) u_clock (.clk(clk), .arst_n(arst_n));

    vector_display_top #(
        .POINT_ADDR_W(POINT_ADDR_W),
        .DWELL_CYCLES(DWELL_CYCLES)
    ) vector_display_top_i (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .x_dac(x_dac), .y_dac(y_dac), .dac_load(dac_load),
        .beam_on(beam_on), .halt(halt)
    );

    //////////////////////////////////////////////////
    // helpers
    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'((lcg_state >> 8) % n);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic step();
        @(posedge clk);
        #1;     // inputs move just after the edge
    endtask

    task automatic compare_coord(input string test, input coord_t exp, input coord_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s expected %0d actual %0d", test, exp, act));
        end
    endtask

    task automatic compare_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s expected %b actual %b", test, exp, act));
        end
    endtask

    task automatic compare_word(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s expected 0x%08h actual 0x%08h", test, exp, act));
        end
    endtask

    task automatic compare_resp(input string test, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s expected %b actual %b", test, exp, act));
        end
    endtask

    // start screen as described for the rom, square entered by one blanked move
    function automatic point_word_t rom_point(input int i);
        point_word_t p;
        p.blank = (i == 0);
        p.last  = (i == START_SCREEN_LEN - 1);
        case (i)
            0:       {p.x, p.y} = {8'd64, 8'd64};
            1:       {p.x, p.y} = {8'd128, 8'd64};
            2:       {p.x, p.y} = {8'd192, 8'd64};
            3:       {p.x, p.y} = {8'd192, 8'd128};
            4:       {p.x, p.y} = {8'd192, 8'd192};
            5:       {p.x, p.y} = {8'd128, 8'd192};
            6:       {p.x, p.y} = {8'd64, 8'd192};
            default: {p.x, p.y} = {8'd64, 8'd128};
        endcase
        return p;
    endfunction

    //////////////////////////////////////////////////
    // axi master, random aw/w gap and bready/rready delay
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        int         gap;
        int         delay;
        int         n;
        bit         aw_first;
        bit         aw_done;
        bit         w_done;
        bit         aw_hs;
        bit         w_hs;
        logic [1:0] resp;
        gap      = rand_below(3);
        aw_first = (rand_below(2) == 1);
        delay    = rand_below(4);
        aw_done  = 1'b0;
        w_done   = 1'b0;
        n        = 0;
        awaddr   = addr;
        wdata    = data;
        wstrb    = 4'hf;
        while (!(aw_done && w_done)) begin
            if (!aw_done && (aw_first || n >= gap)) begin
                awvalid = 1'b1;
            end
            if (!w_done && (!aw_first || n >= gap)) begin
                wvalid = 1'b1;
            end
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            step();
            if (aw_hs) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
            n++;
        end
        repeat (delay) step();
        bready = 1'b1;
        w_hs   = 1'b0;
        while (!w_hs) begin
            @(negedge clk);
            w_hs = bvalid;
            resp = bresp;
            step();
        end
        bready = 1'b0;
        compare_resp($sformatf("write 0x%03h bresp", addr), RESP_OKAY, resp);
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        int         delay;
        bit         hs;
        logic [1:0] resp;
        delay   = rand_below(4);
        araddr  = addr;
        arvalid = 1'b1;
        hs      = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = arready;
            step();
        end
        arvalid = 1'b0;
        repeat (delay) step();
        rready = 1'b1;
        hs     = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs   = rvalid;
            data = rdata;
            resp = rresp;
            step();
        end
        rready = 1'b0;
        compare_resp($sformatf("read 0x%03h rresp", addr), RESP_OKAY, resp);
    endtask

    //////////////////////////////////////////////////
    // frame model and monitor
    task automatic build_frame(input int n);
        for (int i = 0; i < n; i++) begin
            model_ram[i].x     = 8'(rand_below(256));
            model_ram[i].y     = 8'(rand_below(256));
            model_ram[i].blank = (rand_below(4) == 0);
            model_ram[i].last  = (i == n - 1);
            axi_write(POINT_BASE + 12'(4 * i), {14'd0, model_ram[i]});
        end
    endtask

    always @(negedge clk) begin
        if (dac_load) begin
            seen_x.push_back(x_dac);
            seen_y.push_back(y_dac);
            seen_on.push_back(beam_on);
            seen_cyc.push_back(cycle);
        end
        if (halt && !halt_prev) begin
            halt_rises++;
        end
        halt_prev = halt;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > limit) begin
            abort_run($sformatf("timeout after %0d cycles, the display never finished", cycle));
        end
    end

    task automatic clear_seen();
        seen_x.delete();
        seen_y.delete();
        seen_on.delete();
        seen_cyc.delete();
    endtask

    task automatic wait_frame_done(input int rises_before);
        while (halt_rises == rises_before) begin
            step();
        end
    endtask

    // replay order, beam level, dwell spacing, then halt must stay up
    task automatic check_frame(input string test, input logic from_rom, input int n);
        point_word_t exp;
        repeat (QUIET) step();
        compare_bit({test, " halt"}, 1'b1, halt);
        compare_word({test, " points"}, 32'(n), 32'(seen_x.size()));
        for (int i = 0; i < n; i++) begin
            exp = from_rom ? rom_point(i) : model_ram[i];
            compare_coord($sformatf("%s x[%0d]", test, i), exp.x, seen_x[i]);
            compare_coord($sformatf("%s y[%0d]", test, i), exp.y, seen_y[i]);
            compare_bit($sformatf("%s beam_on[%0d]", test, i), ~exp.blank, seen_on[i]);
            if (i > 0) begin
                compare_word($sformatf("%s spacing[%0d]", test, i), 32'(DWELL_CYCLES + 2),
                             32'(seen_cyc[i] - seen_cyc[i - 1]));
            end
        end
    endtask

    task automatic run_frame(input string test, input logic sel, input int n);
        int rises;
        rises = halt_rises;
        clear_seen();
        axi_write(REG_CTRL, {30'd0, sel, 1'b1});
        wait_frame_done(rises);
        frames++;
        check_frame(test, sel, n);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int          n_a;
        int          n_b;
        int          rises;
        logic [31:0] rd;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        n_a     = 1 + rand_below(40);
        n_b     = 10 + rand_below(31);      // long enough for a go mid-frame
        limit   = ((n_a + START_SCREEN_LEN + n_b) * (DWELL_CYCLES + 2)
                   + (n_a + n_b + 8) * 16 + 3 * QUIET + 20) * 4;
        wait (arst_n === 1'b1);
        step();

        build_frame(n_a);                   // written under random back-pressure
        run_frame("ram_frame", 1'b0, n_a);

        run_frame("start_screen", 1'b1, START_SCREEN_LEN);
        axi_read(REG_CTRL, rd);
        compare_word("ctrl readback rom", 32'h2, rd);

        // second go lands while the frame is still drawing
        build_frame(n_b);
        rises = halt_rises;
        clear_seen();
        axi_write(REG_CTRL, 32'h1);
        while (seen_x.size() == 0) begin
            step();
        end
        axi_write(REG_CTRL, 32'h1);
        wait_frame_done(rises);
        frames++;
        check_frame("go_busy", 1'b0, n_b);

        axi_read(REG_STATUS, rd);
        compare_word("status", {16'd0, 8'(frames), 6'd0, 1'b1, 1'b0}, rd);
        axi_read(REG_CTRL, rd);
        compare_word("ctrl readback ram", 32'h0, rd);
        axi_read(POINT_BASE, rd);
        compare_word("point area read", 32'h0, rd);

        if (vector_display_top_i.u_props.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("bound assertion checks reported failures");
        end
    end

endmodule

// File: vector_display_props.sv
// concurrent checks on dac strobe, busy/halt and the axi response channels, bound into the top
module vector_display_props (
    input logic clk,
    input logic arst_n,
    input logic dac_load,
    input logic beam_on,
    input logic busy,
    input logic halt,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    int fail_count = 0;     // read by the testbench at the end

    //////////////////////////////////////////////////
    // sequencer outputs
    dac_load_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        dac_load |=> !dac_load)
        else begin
            fail_count++;
            $error("dac_load high for more than one cycle");
        end

    busy_halt_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(busy && halt))
        else begin
            fail_count++;
            $error("busy and halt high together");
        end

    dark_in_halt: assert property (@(posedge clk) disable iff (!arst_n)
        halt |-> !beam_on)
        else begin
            fail_count++;
            $error("beam on while halted");
        end

    //////////////////////////////////////////////////
    // axi responses stay up until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

endmodule

bind vector_display_top vector_display_props u_props (
    .clk(clk),
    .arst_n(arst_n),
    .dac_load(dac_load),
    .beam_on(beam_on),
    .busy(busy),
    .halt(halt),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready)
);

// File: tb_clock.sv
// testbench clock and reset source, reset held low for a number of clock cycles
module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;   // released just after an edge
    end

endmodule

// File: vector_display_top.sv
// vector display top level: axi host port, frame ram, point source, dwell timer, sequencer
module vector_display_top import vector_pkg::*; #(
    parameter int POINT_ADDR_W = 8,     // 256 points
    parameter int DWELL_CYCLES = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    // axi4-lite slave
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // dac outputs
    output coord_t      x_dac,
    output coord_t      y_dac,
    output logic        dac_load,
    output logic        beam_on,
    output logic        halt
);

    logic                    ram_we;
    logic [POINT_ADDR_W-1:0] ram_waddr;
    point_word_t             ram_wdata;
    point_word_t             ram_rdata;
    logic [POINT_ADDR_W-1:0] rd_addr;
    point_word_t             pt_data;
    logic                    go;
    logic                    screen_sel;
    logic                    busy;
    logic                    timer_start;
    logic                    timer_done;

    //////////////////////////////////////////////////
    // host side
    axil_point_port #(
        .POINT_ADDR_W(POINT_ADDR_W)
    ) u_axil_point_port (
        .clk(clk), .arst_n(arst_n),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .busy(busy), .halt(halt),
        .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
        .go(go), .screen_sel(screen_sel)
    );

    point_ram #(
        .POINT_ADDR_W(POINT_ADDR_W)
    ) u_point_ram (
        .clk(clk),
        .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(rd_addr), .rdata(ram_rdata)
    );

    //////////////////////////////////////////////////
    // display side
    screen_source #(
        .POINT_ADDR_W(POINT_ADDR_W)
    ) u_screen_source (
        .clk(clk), .arst_n(arst_n),
        .screen_sel(screen_sel), .rd_addr(rd_addr),
        .ram_rdata(ram_rdata), .pt_data(pt_data)
    );

    dwell_timer #(
        .DWELL_CYCLES(DWELL_CYCLES)
    ) u_dwell_timer (
        .clk(clk), .arst_n(arst_n),
        .start(timer_start), .done(timer_done)
    );

    beam_sequencer #(
        .POINT_ADDR_W(POINT_ADDR_W)
    ) u_beam_sequencer (
        .clk(clk), .arst_n(arst_n),
        .go(go), .pt_data(pt_data), .timer_done(timer_done),
        .rd_addr(rd_addr), .timer_start(timer_start),
        .x_dac(x_dac), .y_dac(y_dac), .dac_load(dac_load),
        .beam_on(beam_on), .busy(busy), .halt(halt)
    );

endmodule

// File: axil_point_port.sv
// axi4-lite slave for the host: point writes into the frame ram plus control and status regs
module axil_point_port import vector_pkg::*; #(
    parameter int POINT_ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    // write channels
    input  logic [11:0]             awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    // read channels
    input  logic [11:0]             araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    // sequencer status
    input  logic                    busy,
    input  logic                    halt,
    // frame ram and control
    output logic                    ram_we,
    output logic [POINT_ADDR_W-1:0] ram_waddr,
    output point_word_t             ram_wdata,
    output logic                    go,
    output logic                    screen_sel
);

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam int         POINT_END = int'(POINT_BASE) + 4 * (2 ** POINT_ADDR_W);

    logic        port_en;   // readies stay low until out of reset
    logic        aw_full;
    logic        w_full;
    logic [11:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;
    logic        wr_fire;
    logic        wr_point;
    logic        wr_ctrl;
    logic [31:0] rd_word;
    logic        halt_q;
    logic [7:0]  frame_cnt;

    //////////////////////////////////////////////////
    // write path, aw and w may arrive in any order
    assign awready = port_en & ~aw_full & ~bvalid;
    assign wready  = port_en & ~w_full & ~bvalid;
    assign wr_fire = aw_full & w_full;

    assign wr_point = wr_fire && int'(aw_addr_q) >= int'(POINT_BASE)
                      && int'(aw_addr_q) < POINT_END;
    assign wr_ctrl  = wr_fire && (aw_addr_q == REG_CTRL) && w_strb_q[0];

    assign ram_we    = wr_point && (&w_strb_q[2:0]);   // 18-bit word needs three lanes
    assign ram_waddr = aw_addr_q[POINT_ADDR_W+1:2];
    assign ram_wdata = point_word_t'(w_data_q[17:0]);

    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;
    assign arready = port_en & ~rvalid;

    // status word
    always_comb begin
        case (araddr)
            REG_CTRL:   rd_word = {30'd0, screen_sel, 1'b0};
            REG_STATUS: rd_word = {16'd0, frame_cnt, 6'd0, halt, busy};
            default:    rd_word = '0;   // point area reads as zero
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            port_en    <= 1'b0;
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            go         <= 1'b0;
            screen_sel <= 1'b0;
            halt_q     <= 1'b0;
            frame_cnt  <= '0;
        end else begin
            port_en <= 1'b1;
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end else if (wr_fire) begin
                aw_full <= 1'b0;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
            end else if (wr_fire) begin
                w_full <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            go <= wr_ctrl & w_data_q[0] & ~busy;    // one-cycle pulse
            if (wr_ctrl) begin
                screen_sel <= w_data_q[1];
            end
            halt_q <= halt;
            if (halt && !halt_q) begin
                frame_cnt <= frame_cnt + 1'b1;      // one per finished frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (arvalid && arready) begin
            rdata <= rd_word;
        end
    end

endmodule

// File: beam_sequencer.sv
// walks the point list, loads the x/y dacs and holds each point for one dwell period
module beam_sequencer import vector_pkg::*; #(
    parameter int POINT_ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    go,
    input  point_word_t             pt_data,
    input  logic                    timer_done,
    output logic [POINT_ADDR_W-1:0] rd_addr,
    output logic                    timer_start,
    output coord_t                  x_dac,
    output coord_t                  y_dac,
    output logic                    dac_load,
    output logic                    beam_on,
    output logic                    busy,
    output logic                    halt
);

    seq_state_t state;
    seq_state_t state_nxt;
    logic       last_q;     // last flag of the point on screen

    //////////////////////////////////////////////////
    // state machine
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, HALT: begin
                if (go) begin
                    state_nxt = FETCH;
                end
            end
            FETCH:   state_nxt = LOAD;      // word arrives next cycle
            LOAD:    state_nxt = DWELL;
            DWELL: begin
                if (timer_done) begin
                    state_nxt = last_q ? HALT : FETCH;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // frame restarts at 0, otherwise step to the next point
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr <= '0;
        end else if (state_nxt == FETCH) begin
            if (state == DWELL) begin
                rd_addr <= rd_addr + 1'b1;  // wraps at ram depth
            end else begin
                rd_addr <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // dac side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dac_load <= 1'b0;
            beam_on  <= 1'b0;
        end else begin
            dac_load <= (state == LOAD);
            if (state == LOAD) begin
                beam_on <= ~pt_data.blank;
            end else if (state_nxt == HALT) begin
                beam_on <= 1'b0;            // dark between frames
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD) begin
            x_dac  <= pt_data.x;
            y_dac  <= pt_data.y;
            last_q <= pt_data.last;
        end
    end

    assign timer_start = (state == LOAD);
    assign busy        = (state == FETCH) || (state == LOAD) || (state == DWELL);
    assign halt        = (state == HALT);

endmodule

// File: dwell_timer.sv
// dwell counter: started once per point, pulses done after DWELL_CYCLES clocks
module dwell_timer #(
    parameter int DWELL_CYCLES = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic done
);

    localparam int               CNT_W    = $clog2(DWELL_CYCLES + 1);
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(DWELL_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            cnt  <= LOAD_VAL;
            done <= (DWELL_CYCLES == 1);    // single cycle dwell
        end else begin
            done <= (cnt == CNT_W'(1));     // high as the count hits zero
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

// File: screen_source.sv
// picks the frame ram or the start screen rom as the point source of the beam sequencer
module screen_source import vector_pkg::*; #(
    parameter int POINT_ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    screen_sel,
    input  logic [POINT_ADDR_W-1:0] rd_addr,
    input  point_word_t             ram_rdata,
    output point_word_t             pt_data
);

    point_word_t rom_word;
    point_word_t rom_q;
    logic        sel_q;

    //////////////////////////////////////////////////
    // start screen, outlined square entered by one blanked move
    always_comb begin
        case (rd_addr)
            0:       rom_word = '{last: 1'b0, blank: 1'b1, x: 8'd64,  y: 8'd64};
            1:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd128, y: 8'd64};
            2:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd192, y: 8'd64};
            3:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd192, y: 8'd128};
            4:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd192, y: 8'd192};
            5:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd128, y: 8'd192};
            6:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd64,  y: 8'd192};
            7:       rom_word = '{last: 1'b0, blank: 1'b0, x: 8'd64,  y: 8'd128};
            default: rom_word = '{last: 1'b0, blank: 1'b1, x: 8'd128, y: 8'd128};
        endcase
        // anything past the image ends the frame
        if (int'(rd_addr) >= START_SCREEN_LEN - 1) begin
            rom_word.last = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= screen_sel;    // follows the read register of the ram
        end
    end

    always_ff @(posedge clk) begin
        rom_q <= rom_word;
    end

    // both sources are one cycle behind rd_addr here
    assign pt_data = sel_q ? rom_q : ram_rdata;

endmodule

// File: point_ram.sv
// frame ram: the axi port writes points, the display path reads them one cycle later
module point_ram import vector_pkg::*; #(
    parameter int POINT_ADDR_W = 8
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [POINT_ADDR_W-1:0] waddr,
    input  point_word_t             wdata,
    input  logic [POINT_ADDR_W-1:0] raddr,
    output point_word_t             rdata
);

    point_word_t mem [2**POINT_ADDR_W];

    // host side write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr];    // registered read
    end

endmodule

// File: vector_pkg.sv
// shared point format, sequencer states and axi register map, imported by rtl and testbench
package vector_pkg;

    typedef logic [7:0] coord_t;    // one dac code

    // 18-bit point word as stored in the frame ram
    typedef struct packed {
        logic   last;     // final point of the frame
        logic   blank;    // move with the beam off
        coord_t x;
        coord_t y;
    } point_word_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD,
        DWELL,
        HALT
    } seq_state_t;

    //////////////////////////////////////////////////
    // axi register map, byte offsets
    localparam logic [11:0] REG_CTRL   = 12'h000;   // bit 0 go, bit 1 screen_sel
    localparam logic [11:0] REG_STATUS = 12'h004;   // busy, halt, frame count
    localparam logic [11:0] POINT_BASE = 12'h400;   // one word per point

    // start screen rom image
    localparam int START_SCREEN_LEN = 8;

endpackage
